// File: logic/cam_pkg.sv
`default_nettype none

package cam_pkg;

    // camera frame as delivered by the sensor.
    localparam int CAM_W = 16;
    localparam int CAM_H = 12;

    localparam int SCALE_SHIFT = 1;  // keep one pixel and one line in 2**SCALE_SHIFT.

    localparam int FB_W      = CAM_W >> SCALE_SHIFT;
    localparam int FB_H      = CAM_H >> SCALE_SHIFT;
    localparam int FB_PIXELS = FB_W * FB_H;

    localparam int UP_SHIFT = 1;  // stored pixel covers a 2**UP_SHIFT square.
    localparam int DISP_W   = FB_W << UP_SHIFT;
    localparam int DISP_H   = FB_H << UP_SHIFT;

    // reader register, ram read register, format register.
    localparam int READ_LATENCY = 3;

    typedef logic [9:0]                   pos_t;
    typedef logic [$clog2(FB_PIXELS)-1:0] fb_addr_t;
    typedef logic [15:0]                  rgb565_t;  // r5 g6 b5.
    typedef logic [7:0]                   chan_t;

    typedef enum logic [1:0] {
        WAIT_FRAME,
        HIGH_BYTE,
        LOW_BYTE
    } cap_state_e;

endpackage

`default_nettype wire

// File: logic/fb_wr_if.sv
`default_nettype none

interface fb_wr_if;

    logic              wr_en;
    cam_pkg::fb_addr_t wr_addr;
    cam_pkg::rgb565_t  wr_data;
    logic              frame_done;  // single cycle at the end of a captured frame.

    modport cap (
        output wr_en,
        output wr_addr,
        output wr_data,
        output frame_done
    );

    modport mem (
        input wr_en,
        input wr_addr,
        input wr_data
    );

endinterface

`default_nettype wire

// File: logic/camera_capture.sv
`default_nettype none

module camera_capture (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_vsync,
    input  logic       i_href,
    input  logic       i_byte_en,
    input  logic [7:0] i_byte,
    fb_wr_if.cap       o_wr
);

    cam_pkg::cap_state_e state;
    logic                vsync_q;
    logic                href_q;
    logic                vsync_rise;
    logic                href_fall;
    logic                byte_ok;
    logic                lines_seen;
    logic                row_kept;
    logic                keep;
    logic [7:0]          hi_byte;
    cam_pkg::pos_t       row;
    cam_pkg::pos_t       col;
    cam_pkg::fb_addr_t   row_base;  // (row >> SCALE_SHIFT) * FB_W, kept as a running sum.
    cam_pkg::fb_addr_t   col_addr;

    assign vsync_rise = i_vsync & ~vsync_q;
    assign href_fall  = href_q & ~i_href;
    assign byte_ok    = i_byte_en & i_href;

    assign row_kept = ((row & cam_pkg::pos_t'((1 << cam_pkg::SCALE_SHIFT) - 1)) == '0)
                   && (row < cam_pkg::pos_t'(cam_pkg::CAM_H));
    assign keep     = row_kept
                   && ((col & cam_pkg::pos_t'((1 << cam_pkg::SCALE_SHIFT) - 1)) == '0)
                   && (col < cam_pkg::pos_t'(cam_pkg::CAM_W));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state             <= cam_pkg::WAIT_FRAME;
            vsync_q           <= 1'b0;
            href_q            <= 1'b0;
            lines_seen        <= 1'b0;
            row               <= '0;
            col               <= '0;
            row_base          <= '0;
            col_addr          <= '0;
            o_wr.wr_en        <= 1'b0;
            o_wr.frame_done   <= 1'b0;
        end else begin
            vsync_q         <= i_vsync;
            href_q          <= i_href;
            o_wr.wr_en      <= 1'b0;
            o_wr.frame_done <= vsync_rise & lines_seen;  // empty frames are not reported.
            if (vsync_rise) begin
                state      <= cam_pkg::HIGH_BYTE;
                row        <= '0;
                col        <= '0;
                row_base   <= '0;
                col_addr   <= '0;
                lines_seen <= 1'b0;
            end else if (href_fall && state != cam_pkg::WAIT_FRAME) begin
                state      <= cam_pkg::HIGH_BYTE;  // resync the byte pairing per line.
                row        <= row + 1'b1;
                col        <= '0;
                col_addr   <= '0;
                lines_seen <= 1'b1;
                if (row_kept) begin
                    row_base <= row_base + cam_pkg::fb_addr_t'(cam_pkg::FB_W);
                end
            end else if (byte_ok) begin
                case (state)
                    cam_pkg::HIGH_BYTE: state <= cam_pkg::LOW_BYTE;
                    cam_pkg::LOW_BYTE: begin
                        state <= cam_pkg::HIGH_BYTE;
                        col   <= col + 1'b1;
                        if (keep) begin
                            o_wr.wr_en <= 1'b1;
                            col_addr   <= col_addr + 1'b1;
                        end
                    end
                    default: state <= state;  // bytes before the first vsync are dropped.
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (byte_ok && state == cam_pkg::HIGH_BYTE) begin
            hi_byte <= i_byte;
        end
        if (byte_ok && state == cam_pkg::LOW_BYTE) begin
            o_wr.wr_data <= {hi_byte, i_byte};
            o_wr.wr_addr <= row_base + col_addr;
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_buffer.sv
`default_nettype none

module frame_buffer (
    input  logic              i_clk,
    fb_wr_if.mem              i_wr,
    input  logic              i_rd_en,
    input  cam_pkg::fb_addr_t i_rd_addr,
    output cam_pkg::rgb565_t  o_rd_data
);

    cam_pkg::rgb565_t mem [cam_pkg::FB_PIXELS];

    always_ff @(posedge i_clk) begin
        if (i_wr.wr_en) begin
            mem[i_wr.wr_addr] <= i_wr.wr_data;
        end
    end

    // read before write on a shared address.
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/fb_reader.sv
`default_nettype none

module fb_reader (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_frame,
    input  logic              i_line,
    input  cam_pkg::pos_t     i_x,
    input  cam_pkg::pos_t     i_y,
    output logic              o_rd_en,
    output cam_pkg::fb_addr_t o_rd_addr,
    output logic              o_pix_valid
);

    logic                         active;
    logic [cam_pkg::UP_SHIFT-1:0] x_rep;
    logic [cam_pkg::UP_SHIFT-1:0] y_rep;
    logic [cam_pkg::UP_SHIFT-1:0] x_rep_now;
    logic [cam_pkg::UP_SHIFT-1:0] y_rep_now;
    cam_pkg::fb_addr_t            addr;
    cam_pkg::fb_addr_t            addr_now;
    cam_pkg::fb_addr_t            line_start;  // held for the repeated lines.
    cam_pkg::fb_addr_t            line_start_now;
    logic                         line_used;
    logic                         line_used_now;

    assign active = (i_x < cam_pkg::pos_t'(cam_pkg::DISP_W))
                 && (i_y < cam_pkg::pos_t'(cam_pkg::DISP_H));

    // counters as seen by this cycle's position, so a pulse may share a cycle with x = 0.
    always_comb begin
        addr_now       = addr;
        line_start_now = line_start;
        x_rep_now      = x_rep;
        y_rep_now      = y_rep;
        line_used_now  = line_used;
        if (i_frame) begin
            addr_now       = '0;
            line_start_now = '0;
            x_rep_now      = '0;
            y_rep_now      = '0;
            line_used_now  = 1'b0;
        end else if (i_line) begin
            x_rep_now     = '0;
            line_used_now = 1'b0;
            if (line_used) begin  // blank lines do not count as repeats.
                y_rep_now = y_rep + 1'b1;
                if (&y_rep) begin
                    line_start_now = line_start + cam_pkg::fb_addr_t'(cam_pkg::FB_W);
                end
            end
            addr_now = line_start_now;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rd_en     <= 1'b0;
            o_pix_valid <= 1'b0;
            addr        <= '0;
            line_start  <= '0;
            x_rep       <= '0;
            y_rep       <= '0;
            line_used   <= 1'b0;
        end else begin
            o_rd_en     <= active;
            o_pix_valid <= o_rd_en;  // lines up with the ram output.
            addr        <= addr_now;
            line_start  <= line_start_now;
            x_rep       <= x_rep_now;
            y_rep       <= y_rep_now;
            line_used   <= line_used_now;
            if (active) begin
                x_rep     <= x_rep_now + 1'b1;
                line_used <= 1'b1;
                if (&x_rep_now) begin
                    addr <= addr_now + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (active) begin
            o_rd_addr <= addr_now;
        end
    end

endmodule

`default_nettype wire

// File: logic/pixel_format.sv
`default_nettype none

module pixel_format (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_gray_toggle,
    input  logic             i_pix_valid,
    input  cam_pkg::rgb565_t i_pix,
    output logic             o_valid,
    output cam_pkg::chan_t   o_rgb [3]  // red, green, blue.
);

    logic           gray_mode;
    cam_pkg::chan_t red8;
    cam_pkg::chan_t green8;
    cam_pkg::chan_t blue8;
    cam_pkg::chan_t luma;
    logic [15:0]    luma_sum;  // weights add up to 256, so no overflow.

    assign red8   = {i_pix[15:11], 3'b000};
    assign green8 = {i_pix[10:5], 2'b00};
    assign blue8  = {i_pix[4:0], 3'b000};

    assign luma_sum = 16'd77 * {8'd0, red8}
                    + 16'd150 * {8'd0, green8}
                    + 16'd29 * {8'd0, blue8};
    assign luma     = luma_sum[15:8];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            gray_mode <= 1'b0;
            o_valid   <= 1'b0;
            o_rgb     <= '{default: '0};
        end else begin
            if (i_gray_toggle) begin
                gray_mode <= ~gray_mode;
            end
            o_valid <= i_pix_valid;
            if (!i_pix_valid) begin
                o_rgb <= '{default: '0};  // border is black.
            end else if (gray_mode) begin
                o_rgb <= '{luma, luma, luma};
            end else begin
                o_rgb <= '{red8, green8, blue8};
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/camera_fb_top.sv
`default_nettype none

module camera_fb_top (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_vsync,
    input  logic           i_href,
    input  logic           i_byte_en,
    input  logic [7:0]     i_byte,
    input  logic           i_frame,
    input  logic           i_line,
    input  cam_pkg::pos_t  i_x,
    input  cam_pkg::pos_t  i_y,
    input  logic           i_gray_toggle,
    output logic           o_valid,
    output cam_pkg::chan_t o_red,
    output cam_pkg::chan_t o_green,
    output cam_pkg::chan_t o_blue,
    output logic           o_frame_captured
);

    logic              rd_en;
    cam_pkg::fb_addr_t rd_addr;
    cam_pkg::rgb565_t  rd_data;
    logic              pix_valid;
    cam_pkg::chan_t    rgb [3];

    fb_wr_if fb_wr ();

    camera_capture u_camera_capture (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_vsync   (i_vsync),
        .i_href    (i_href),
        .i_byte_en (i_byte_en),
        .i_byte    (i_byte),
        .o_wr      (fb_wr.cap)
    );

    frame_buffer u_frame_buffer (
        .i_clk     (i_clk),
        .i_wr      (fb_wr.mem),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    fb_reader u_fb_reader (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_frame     (i_frame),
        .i_line      (i_line),
        .i_x         (i_x),
        .i_y         (i_y),
        .o_rd_en     (rd_en),
        .o_rd_addr   (rd_addr),
        .o_pix_valid (pix_valid)
    );

    pixel_format u_pixel_format (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_gray_toggle (i_gray_toggle),
        .i_pix_valid   (pix_valid),
        .i_pix         (rd_data),
        .o_valid       (o_valid),
        .o_rgb         (rgb)
    );

    assign o_frame_captured = fb_wr.frame_done;
    assign o_red            = rgb[0];
    assign o_green          = rgb[1];
    assign o_blue           = rgb[2];

endmodule

`default_nettype wire

// File: tb/camera_fb_chk.sv
`default_nettype none

module camera_fb_chk (
    input wire logic              i_clk,
    input wire logic              i_rst,
    input wire cam_pkg::pos_t     i_x,
    input wire cam_pkg::pos_t     i_y,
    input wire logic              o_valid,
    input wire logic              wr_en,
    input wire cam_pkg::fb_addr_t wr_addr,
    input wire logic              frame_done
);

    timeunit 1ns;
    timeprecision 1ps;

    logic active;

    assign active = (i_x < cam_pkg::pos_t'(cam_pkg::DISP_W))
                 && (i_y < cam_pkg::pos_t'(cam_pkg::DISP_H));

    a_valid_after_reset: assert property (@(posedge i_clk) i_rst |=> !o_valid)
        else $error("o_valid high in the cycle after reset");

    a_wr_addr_range: assert property (@(posedge i_clk) disable iff (i_rst)
        wr_en |-> (int'(wr_addr) < cam_pkg::FB_PIXELS))
        else $error("framebuffer write address out of range");

    // frame_done is a single cycle pulse.
    a_frame_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        frame_done |=> !frame_done)
        else $error("frame_done held longer than one cycle");

    a_valid_latency: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid == $past(active, cam_pkg::READ_LATENCY))
        else $error("o_valid does not follow the active position");

endmodule

bind camera_fb_top camera_fb_chk camera_fb_chk (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_x        (i_x),
    .i_y        (i_y),
    .o_valid    (o_valid),
    .wr_en      (fb_wr.wr_en),
    .wr_addr    (fb_wr.wr_addr),
    .frame_done (fb_wr.frame_done)
);

`default_nettype wire

// File: tb/camera_fb_tb.sv
`default_nettype none

module camera_fb_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NVEC   = 8;
    localparam int SCAN_W = 20;
    localparam int SCAN_H = 14;
    localparam int NCAM   = cam_pkg::CAM_W * cam_pkg::CAM_H;

    logic          clk;
    logic          rst;
    logic          vsync;
    logic          href;
    logic          byte_en;
    logic [7:0]    cam_byte;
    logic          frame;
    logic          line;
    cam_pkg::pos_t x;
    cam_pkg::pos_t y;
    logic          gray_toggle;
    logic          o_valid;
    logic [7:0]    o_red;
    logic [7:0]    o_green;
    logic [7:0]    o_blue;
    logic          o_frame_captured;

    logic [47:0] vec [NVEC];          // rgb565, rgb888, gray.
    logic [15:0] cam_pix [NCAM];
    logic [23:0] exp_cam [NCAM];      // expected output per camera pixel.
    integer      seed;
    int          errors;
    int          tests;
    int          failed_tests;
    int          test_start_errors;
    int          first_valid;

    camera_fb_top u_camera_fb_top (
        .i_clk            (clk),
        .i_rst            (rst),
        .i_vsync          (vsync),
        .i_href           (href),
        .i_byte_en        (byte_en),
        .i_byte           (cam_byte),
        .i_frame          (frame),
        .i_line           (line),
        .i_x              (x),
        .i_y              (y),
        .i_gray_toggle    (gray_toggle),
        .o_valid          (o_valid),
        .o_red            (o_red),
        .o_green          (o_green),
        .o_blue           (o_blue),
        .o_frame_captured (o_frame_captured)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAILED", name);
        end
    endtask

    // plain bit expansion of the rgb565 fields.
    function automatic logic [23:0] expand565(input logic [15:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    task automatic send_frame();
        int  row;
        int  col;
        int  waited;
        logic [15:0] p;
        @(negedge clk) vsync = 1'b1;
        @(negedge clk) vsync = 1'b0;
        repeat (2) @(negedge clk);
        for (row = 0; row < cam_pkg::CAM_H; row++) begin
            for (col = 0; col < cam_pkg::CAM_W; col++) begin
                p = cam_pix[row * cam_pkg::CAM_W + col];
                @(negedge clk);
                href     = 1'b1;
                byte_en  = 1'b1;
                cam_byte = p[15:8];  // high byte first.
                @(negedge clk) cam_byte = p[7:0];
            end
            @(negedge clk);
            href    = 1'b0;
            byte_en = 1'b0;
            repeat (2) @(negedge clk);
        end
        // the next vsync rise closes the frame.
        @(negedge clk) vsync = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!o_frame_captured && waited < 20);
        if (!o_frame_captured) begin
            $display("timeout: o_frame_captured never came after the frame ended");
            errors++;
        end
        vsync = 1'b0;
    endtask

    task automatic scan_display(input string name);
        int   k;
        int   px;
        int   py;
        int   idx;
        bit   act;
        logic [23:0] expv;
        first_valid = -1;
        for (k = 0; k < SCAN_W * SCAN_H + cam_pkg::READ_LATENCY; k++) begin
            @(negedge clk);
            if (o_valid && first_valid < 0) begin
                first_valid = k;
            end
            if (k >= cam_pkg::READ_LATENCY) begin
                px   = (k - cam_pkg::READ_LATENCY) % SCAN_W;
                py   = (k - cam_pkg::READ_LATENCY) / SCAN_W;
                act  = (px < cam_pkg::DISP_W) && (py < cam_pkg::DISP_H);
                idx  = (((py >> cam_pkg::UP_SHIFT) << cam_pkg::SCALE_SHIFT) * cam_pkg::CAM_W)
                     + ((px >> cam_pkg::UP_SHIFT) << cam_pkg::SCALE_SHIFT);
                expv = act ? exp_cam[idx] : 24'h0;  // border is black.
                check($sformatf("%s valid x=%0d y=%0d", name, px, py),
                      {31'd0, act}, {31'd0, o_valid});
                check($sformatf("%s rgb x=%0d y=%0d", name, px, py),
                      {8'd0, expv}, {8'd0, o_red, o_green, o_blue});
            end
            if (k < SCAN_W * SCAN_H) begin
                x     = cam_pkg::pos_t'(k % SCAN_W);
                y     = cam_pkg::pos_t'(k / SCAN_W);
                frame = (k == 0);
                line  = (k % SCAN_W == 0);
            end else begin
                x     = '1;
                y     = '1;
                frame = 1'b0;
                line  = 1'b0;
            end
        end
    endtask

    task automatic toggle_mode();
        @(negedge clk) gray_toggle = 1'b1;
        @(negedge clk) gray_toggle = 1'b0;
    endtask

    task automatic fill_random();
        int i;
        for (i = 0; i < NCAM; i++) begin
            cam_pix[i] = 16'($random(seed));
            exp_cam[i] = expand565(cam_pix[i]);
        end
    endtask

    initial begin
        int v;
        int i;
        seed         = 74;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        rst          = 1'b1;
        vsync        = 1'b0;
        href         = 1'b0;
        byte_en      = 1'b0;
        cam_byte     = 8'h00;
        frame        = 1'b0;
        line         = 1'b0;
        x            = '1;
        y            = '1;
        gray_toggle  = 1'b0;
        $readmemh("tb/camera_stimulus.mem", vec);
        if (^vec[NVEC - 1] === 1'bx) begin
            $display("stimulus file tb/camera_stimulus.mem is missing or short");
            errors++;
        end

        repeat (8) @(posedge clk);
        @(negedge clk) rst = 1'b0;

        begin_test();
        @(negedge clk);
        check("reset valid", 32'd0, {31'd0, o_valid});
        check("reset captured", 32'd0, {31'd0, o_frame_captured});
        check("reset rgb", 32'd0, {8'd0, o_red, o_green, o_blue});
        end_test("reset");

        for (v = 0; v < NVEC; v++) begin
            begin_test();
            for (i = 0; i < NCAM; i++) begin
                cam_pix[i] = vec[v][47:32];
                exp_cam[i] = vec[v][31:8];
            end
            send_frame();
            scan_display($sformatf("colour_%0d", v));
            end_test($sformatf("colour_%0d", v));
        end

        toggle_mode();
        for (v = 0; v < NVEC; v++) begin
            begin_test();
            for (i = 0; i < NCAM; i++) begin
                cam_pix[i] = vec[v][47:32];
                exp_cam[i] = {vec[v][7:0], vec[v][7:0], vec[v][7:0]};
            end
            send_frame();
            scan_display($sformatf("gray_%0d", v));
            end_test($sformatf("gray_%0d", v));
        end

        toggle_mode();
        begin_test();
        fill_random();
        send_frame();
        scan_display("random_a");
        check("latency", 32'(cam_pkg::READ_LATENCY), 32'(first_valid));
        end_test("random_a");

        // second frame has to replace every stored pixel.
        begin_test();
        fill_random();
        send_frame();
        scan_display("random_b");
        end_test("random_b");

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/cam_pkg.sv
logic/fb_wr_if.sv
logic/camera_capture.sv
logic/frame_buffer.sv
logic/fb_reader.sv
logic/pixel_format.sv
logic/camera_fb_top.sv
tb/camera_fb_chk.sv
tb/camera_fb_tb.sv

// File: Makefile
SRCS := $(wildcard logic/*.sv tb/*.sv)
SIM  := obj_dir/Vcamera_fb_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) files.f
	verilator --binary --timing --assert -f files.f --top-module camera_fb_tb -Mdir obj_dir

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: tb/camera_stimulus.mem
// columns: rgb565 (4 hex) | expected rgb888 (6 hex) | expected gray (2 hex), no spaces
// black, white, red, green, blue, mid gray, yellow, mixed
0000000000000000
FFFFF8FCF8FA
F800F800004A
07E000FC0093
001F0000F81C
841080808080
FFE0F8FC00DE
12341044A03E
